/* sim.f */
+incdir+verification
rtl/eth_pkg.sv
rtl/eth_frame_buf.sv
rtl/eth_reg_decode.sv
rtl/eth_mii_tx.sv
rtl/eth_mii_rx.sv
rtl/eth_core.sv
verification/eth_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= eth_core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -qF '*** PASSED ***' $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verification/eth_core_tests.svh */
task automatic test_reset_regs();
   int e0;
   e0 = errors;
   if (cpu_out.ack !== 1'b0) report_mismatch("cpu_out.ack", 32'(cpu_out.ack), 32'd0);
   if (phy_resetn !== 1'b0) report_mismatch("phy_resetn", 32'(phy_resetn), 32'd0);
   check_reg("STATUS.phy_ready", STATUS, ST_PHY, 32'h0);
   next_cycle(PHY_RST_CYCLES + 8);
   if (phy_resetn !== 1'b1) report_mismatch("phy_resetn", 32'(phy_resetn), 32'd1);
   check_reg("STATUS.phy_ready", STATUS, ST_PHY, ST_PHY);
   check_reg("STATUS.tx_ready", STATUS, ST_TX_READY, ST_TX_READY);
   check_reg("TX_NBYTES", TX_NBYTES, ALL_BITS, 32'd60);
   cpu_write(SCRATCH, 32'hA5A5_1234, 4'hF);
   check_reg("SCRATCH", SCRATCH, ALL_BITS, 32'hA5A5_1234);
   // Partial lanes into the TX window
   cpu_write(BUF_BASE, 32'h1111_2222, 4'b0011);
   cpu_write(BUF_BASE | 12'h001, 32'h3333_4444, 4'b1000);
   report_test("reset_regs", e0);
endtask

task automatic test_transmit();
   int          e0;
   int          frames0;
   logic        bad;
   logic [7:0]  pay[$];
   logic [3:0]  exp_nib[$];
   logic [31:0] fcs;
   e0 = errors;
   for (int i = 0; i < 60; i++) pay.push_back(8'($random(seed)));
   cpu_write(TX_NBYTES, 32'd60, 4'hF);
   // Each word in two halves with junk in the masked lanes
   for (int w = 0; w < 15; w++) begin
      cpu_write(BUF_BASE | 12'(w), {16'hDEAD, pay[4*w+1], pay[4*w]}, 4'b0011);
      cpu_write(BUF_BASE | 12'(w), {pay[4*w+3], pay[4*w+2], 16'hBEEF}, 4'b1100);
   end
   fcs = crc_model(pay);
   for (int i = 0; i < 15; i++) exp_nib.push_back(4'h5);
   exp_nib.push_back(4'hD);
   foreach (pay[i]) begin
      exp_nib.push_back(pay[i][3:0]);
      exp_nib.push_back(pay[i][7:4]);
   end
   for (int i = 0; i < 8; i++) exp_nib.push_back(fcs[4*i +: 4]);
   tx_nibbles.delete();
   frames0 = frames_seen;
   cpu_write(SEND, 32'd1, 4'hF);
   wait_tx(1'b1);
   // SEND while busy is dropped
   cpu_write(SEND, 32'd1, 4'hF);
   wait_tx(1'b0);
   next_cycle(IFG_CYCLES + 40);
   if (frames_seen - frames0 != 1) begin
      report_mismatch("frames on tx_en", 32'(frames_seen - frames0), 32'd1);
   end
   if (tx_nibbles.size() != 16 + 2 * pay.size() + 8) begin
      report_mismatch("tx_en cycles", 32'(tx_nibbles.size()), 32'(16 + 2 * pay.size() + 8));
   end else begin
      bad = 1'b0;
      foreach (exp_nib[i]) begin
         if (!bad && (tx_nibbles[i] !== exp_nib[i])) begin
            report_mismatch($sformatf("tx_data[%0d]", i), 32'(tx_nibbles[i]), 32'(exp_nib[i]));
            bad = 1'b1;
         end
      end
   end
   report_test("transmit", e0);
endtask

task automatic test_receive_own();
   int e0;
   e0 = errors;
   make_frame(MAC_ADDR, 60);
   drive_frame();
   check_reg("STATUS rx flags", STATUS, ST_RX_DONE | ST_CRC_OK | ST_ADDR,
             ST_RX_DONE | ST_CRC_OK | ST_ADDR);
   check_reg("RCV_SIZE", RCV_SIZE, ALL_BITS, 32'(frame_q.size()));
   check_rx_buffer();
   check_reg("RX_CRC", RX_CRC, ALL_BITS, frame_fcs);
   cpu_write(RCVACK, 32'd1, 4'hF);
   check_reg("STATUS.rx_done", STATUS, ST_RX_DONE, 32'h0);
   report_test("receive_own", e0);
endtask

task automatic test_filter_errors();
   int e0;
   e0 = errors;
   make_frame(48'h02_00_00_00_00_02, 60);
   drive_frame();
   check_reg("STATUS.rx_done other addr", STATUS, ST_RX_DONE, 32'h0);
   make_frame(48'hFF_FF_FF_FF_FF_FF, 44);
   drive_frame();
   check_reg("STATUS broadcast", STATUS, ST_RX_DONE | ST_CRC_OK | ST_ADDR,
             ST_RX_DONE | ST_CRC_OK | ST_ADDR);
   cpu_write(RCVACK, 32'd1, 4'hF);
   make_frame(MAC_ADDR, 52);
   frame_q[20] = frame_q[20] ^ 8'h10;
   drive_frame();
   check_reg("STATUS bad crc", STATUS, ST_RX_DONE | ST_CRC_OK, ST_RX_DONE);
   check_reg("RCV_SIZE", RCV_SIZE, ALL_BITS, 32'd56);
   // Held frame blocks the next one
   make_frame(MAC_ADDR, 36);
   drive_frame();
   check_reg("RCV_SIZE while held", RCV_SIZE, ALL_BITS, 32'd56);
   cpu_write(RCVACK, 32'd1, 4'hF);
   report_test("filter_errors", e0);
endtask

task automatic test_soft_reset();
   int e0;
   e0 = errors;
   make_frame(MAC_ADDR, 40);
   drive_frame();
   check_reg("STATUS.rx_done before", STATUS, ST_RX_DONE, ST_RX_DONE);
   cpu_write(SCRATCH, 32'h1234_5678, 4'hF);
   cpu_write(TX_NBYTES, 32'd100, 4'hF);
   cpu_write(SOFTRST, 32'd1, 4'hF);
   if (phy_resetn !== 1'b0) report_mismatch("phy_resetn", 32'(phy_resetn), 32'd0);
   check_reg("SCRATCH", SCRATCH, ALL_BITS, 32'h0);
   check_reg("TX_NBYTES", TX_NBYTES, ALL_BITS, 32'd60);
   check_reg("STATUS after soft reset", STATUS, ST_RX_DONE | ST_PHY, 32'h0);
   report_test("soft_reset", e0);
endtask

/* verification/eth_core_tb.sv */
`timescale 1ns/10ps

module eth_core_tb import eth_pkg::*; ();

   localparam logic [47:0] MAC_ADDR       = 48'h02_00_00_00_00_01;
   localparam int          PHY_RST_CYCLES = 255;
   // Well above the roughly 1500 cycles the tests take
   localparam int          TIMEOUT_CYCLES = 20000;
   localparam logic [11:0] BUF_BASE       = 12'h800;
   localparam logic [31:0] ALL_BITS       = 32'hFFFF_FFFF;

   // STATUS bit positions
   localparam logic [31:0] ST_TX_READY = 32'h01;
   localparam logic [31:0] ST_RX_DONE  = 32'h02;
   localparam logic [31:0] ST_CRC_OK   = 32'h04;
   localparam logic [31:0] ST_ADDR     = 32'h08;
   localparam logic [31:0] ST_PHY      = 32'h10;

   logic        clk;
   logic        rst_int;
   cpu_req_t    cpu_in;
   cpu_rsp_t    cpu_out;
   logic        phy_resetn;
   logic        tx_en;
   logic [3:0]  tx_data;
   logic        rx_dv;
   logic [3:0]  rx_data;

   integer      seed;
   int          cycle_cnt = 0;
   int          errors;
   int          tests_run;
   int          frames_seen;
   logic        tx_en_prev;
   logic [3:0]  tx_nibbles[$];
   logic [7:0]  frame_q[$];
   logic [31:0] frame_fcs;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   eth_core #(.MAC_ADDR(MAC_ADDR), .PHY_RST_CYCLES(PHY_RST_CYCLES)) i_eth_core (
      .clk(clk), .rst_int(rst_int), .cpu_in(cpu_in), .cpu_out(cpu_out),
      .phy_resetn(phy_resetn), .tx_en(tx_en), .tx_data(tx_data),
      .rx_dv(rx_dv), .rx_data(rx_data)
   );

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles, a wait on the DUT never ended", cycle_cnt);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // TX monitor takes one nibble per cycle while tx_en is high
   always @(negedge clk) begin
      if (tx_en) tx_nibbles.push_back(tx_data);
      if (tx_en && !tx_en_prev) frames_seen++;
      tx_en_prev = tx_en;
   end

   task automatic next_cycle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic wait_ack(input logic level);
      int n;
      n = 0;
      do begin
         next_cycle(1);
         n++;
      end while (cpu_out.ack !== level);
      // ack follows req by exactly one edge
      if (n != 1) begin
         errors++;
         $display("Bus ack at %0t took %0d cycles to follow req, expected 1", $time, n);
      end
   endtask

   task automatic wait_tx(input logic level);
      while (tx_en !== level) next_cycle(1);
   endtask

   task automatic cpu_write(input logic [11:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      cpu_in.req   = 1'b1;
      cpu_in.we    = 1'b1;
      cpu_in.addr  = addr;
      cpu_in.wdata = data;
      cpu_in.wstrb = strb;
      wait_ack(1'b1);
      cpu_in.req = 1'b0;
      cpu_in.we  = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic cpu_read(input logic [11:0] addr, output logic [31:0] data);
      cpu_in.req  = 1'b1;
      cpu_in.we   = 1'b0;
      cpu_in.addr = addr;
      wait_ack(1'b1);
      data = cpu_out.rdata;
      cpu_in.req = 1'b0;
      wait_ack(1'b0);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
   endtask

   task automatic check_reg(input string name, input logic [11:0] addr,
                            input logic [31:0] mask, input logic [31:0] exp);
      logic [31:0] got;
      cpu_read(addr, got);
      if ((got & mask) !== exp) report_mismatch(name, got & mask, exp);
   endtask

   task automatic report_test(input string name, input int errs_before);
      tests_run++;
      if (errors == errs_before) $display("%s: ok", name);
      else $display("%s: %0d errors", name, errors - errs_before);
   endtask

   // Bit-serial reflected CRC-32 giving the complemented FCS
   function automatic logic [31:0] crc_model(input logic [7:0] bytes[$]);
      logic [31:0] crc;
      logic        fb;
      crc = 32'hFFFF_FFFF;
      foreach (bytes[i]) begin
         for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ bytes[i][b];
            crc = {1'b0, crc[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
         end
      end
      return ~crc;
   endfunction

   // Destination high byte first then random bytes and the FCS
   task automatic make_frame(input logic [47:0] dest, input int len);
      frame_q.delete();
      for (int i = 0; i < 6; i++) begin
         frame_q.push_back(dest[47-8*i -: 8]);
      end
      while (frame_q.size() < len) begin
         frame_q.push_back(8'($random(seed)));
      end
      frame_fcs = crc_model(frame_q);
      for (int i = 0; i < 4; i++) begin
         frame_q.push_back(frame_fcs[8*i +: 8]);
      end
   endtask

   task automatic drive_frame();
      rx_dv = 1'b1;
      for (int i = 0; i < 16; i++) begin
         rx_data = (i == 15) ? 4'hD : 4'h5;
         next_cycle(1);
      end
      foreach (frame_q[i]) begin
         rx_data = frame_q[i][3:0];
         next_cycle(1);
         rx_data = frame_q[i][7:4];
         next_cycle(1);
      end
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      next_cycle(2);
   endtask

   task automatic check_rx_buffer();
      logic [31:0] got;
      logic [31:0] exp;
      for (int w = 0; w < frame_q.size() / 4; w++) begin
         exp = {frame_q[4*w+3], frame_q[4*w+2], frame_q[4*w+1], frame_q[4*w]};
         cpu_read(BUF_BASE | 12'(w), got);
         if (got !== exp) report_mismatch($sformatf("rx_buf[%0d]", w), got, exp);
      end
   endtask

   `include "eth_core_tests.svh"

   initial begin
      seed        = 32'hb45593d7;
      errors      = 0;
      tests_run   = 0;
      frames_seen = 0;
      tx_en_prev  = 1'b0;
      rst_int     = 1'b1;
      cpu_in      = '0;
      rx_dv       = 1'b0;
      rx_data     = 4'h0;
      repeat (4) @(posedge clk);
      #1;
      rst_int = 1'b0;
      test_reset_regs();
      test_transmit();
      test_receive_own();
      test_filter_errors();
      test_soft_reset();
      $display("Summary: %0d tests run, %0d errors", tests_run, errors);
      if (errors == 0) $display("*** PASSED ***");
      else $display("*** FAILED ***");
      $finish;
   end

endmodule

/* rtl/eth_core.sv */
`timescale 1ns/10ps

module eth_core import eth_pkg::*; #(
   parameter logic [47:0] MAC_ADDR       = 48'h02_00_00_00_00_01,
   parameter int          PHY_RST_CYCLES = 1048575
) (
   input  logic       clk,
   input  logic       rst_int,
   input  cpu_req_t   cpu_in,
   output cpu_rsp_t   cpu_out,
   output logic       phy_resetn,
   output logic       tx_en,
   output logic [3:0] tx_data,
   input  logic       rx_dv,
   input  logic [3:0] rx_data
);

   buf_wr_t               tx_wr;
   buf_wr_t               rx_wr;
   logic [BUF_ADDR_W-1:0] tx_rd_addr;
   logic [BUF_ADDR_W-1:0] rx_rd_addr;
   logic [31:0]           tx_rd_data;
   logic [31:0]           rx_rd_data;
   logic                  send_start;
   logic                  rx_ack;
   logic [10:0]           tx_nbytes;
   logic                  soft_rst;
   logic                  rst_core;
   logic                  tx_ready;
   logic                  rx_done;
   logic                  crc_ok;
   logic                  addr_match;
   logic [10:0]           rx_len;
   logic [31:0]           rx_fcs;
   eth_status_t           status;

   assign rst_core = rst_int | soft_rst;

   // phy_ready is filled in by the decoder
   assign status = '{rsvd: '0, phy_ready: 1'b0, addr_match: addr_match,
                     crc_ok: crc_ok, rx_done: rx_done, tx_ready: tx_ready};

   eth_reg_decode #(.PHY_RST_CYCLES(PHY_RST_CYCLES)) i_reg_decode (
      .clk(clk), .rst_int(rst_int), .cpu_in(cpu_in), .cpu_out(cpu_out),
      .tx_wr(tx_wr), .rx_rd_addr(rx_rd_addr), .rx_rd_data(rx_rd_data),
      .status(status), .rx_len(rx_len), .rx_fcs(rx_fcs),
      .send_start(send_start), .rx_ack(rx_ack), .tx_nbytes(tx_nbytes),
      .soft_rst(soft_rst), .phy_resetn(phy_resetn)
   );

   eth_frame_buf tx_buf (
      .clk(clk), .wr(tx_wr), .rd_addr(tx_rd_addr), .rd_data(tx_rd_data)
   );

   eth_frame_buf rx_buf (
      .clk(clk), .wr(rx_wr), .rd_addr(rx_rd_addr), .rd_data(rx_rd_data)
   );

   eth_mii_tx i_mii_tx (
      .clk(clk), .rst_int(rst_core), .send_start(send_start), .nbytes(tx_nbytes),
      .phy_ready(phy_resetn), .rd_addr(tx_rd_addr), .rd_data(tx_rd_data),
      .tx_ready(tx_ready), .tx_en(tx_en), .tx_data(tx_data)
   );

   eth_mii_rx #(.MAC_ADDR(MAC_ADDR)) i_mii_rx (
      .clk(clk), .rst_int(rst_core), .rx_dv(rx_dv), .rx_data(rx_data),
      .rx_ack(rx_ack), .wr(rx_wr), .rx_done(rx_done), .crc_ok(crc_ok),
      .addr_match(addr_match), .rx_len(rx_len), .rx_fcs(rx_fcs)
   );

endmodule

/* rtl/eth_mii_rx.sv */
`timescale 1ns/10ps

module eth_mii_rx import eth_pkg::*; #(
   parameter logic [47:0] MAC_ADDR = 48'h02_00_00_00_00_01
) (
   input  logic        clk,
   input  logic        rst_int,
   input  logic        rx_dv,
   input  logic [3:0]  rx_data,
   input  logic        rx_ack,
   output buf_wr_t     wr,
   output logic        rx_done,
   output logic        crc_ok,
   output logic        addr_match,
   output logic [10:0] rx_len,
   output logic [31:0] rx_fcs
);

   rx_state_e   state;
   logic        nib_hi;
   logic [3:0]  low_nib;
   logic [7:0]  cur_byte;
   logic        byte_done;
   logic [10:0] byte_cnt;
   logic [31:0] crc;
   logic [47:0] dest_exp;
   logic        own_ok;
   logic        bcast_ok;
   logic        addr_ok;
   logic        wr_we;
   logic [7:0]  wr_byte;
   logic [10:0] wr_pos;

   assign cur_byte  = {rx_data, low_nib};
   assign byte_done = (state == RX_DATA) && rx_dv && nib_hi;
   assign addr_ok   = (own_ok || bcast_ok) && (byte_cnt >= 11'd6);
   assign rx_len    = byte_cnt;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state      <= RX_IDLE;
         nib_hi     <= 1'b0;
         byte_cnt   <= '0;
         wr_we      <= 1'b0;
         rx_done    <= 1'b0;
         crc_ok     <= 1'b0;
         addr_match <= 1'b0;
      end else begin
         wr_we <= byte_done;
         case (state)
            RX_IDLE: if (rx_dv && (rx_data == 4'h5)) state <= RX_PRE;
            RX_PRE: begin
               if (!rx_dv || ((rx_data != 4'h5) && (rx_data != 4'hD))) begin
                  state <= RX_IDLE;
               end else if (rx_data == 4'hD) begin
                  state    <= RX_DATA;
                  nib_hi   <= 1'b0;
                  byte_cnt <= '0;
               end
            end
            RX_DATA: begin
               if (!rx_dv) begin
                  // Frames for other stations are dropped silently
                  state <= addr_ok ? RX_DONE : RX_IDLE;
                  if (addr_ok) begin
                     rx_done    <= 1'b1;
                     crc_ok     <= (crc == CRC_RESIDUE);
                     addr_match <= 1'b1;
                  end
               end else begin
                  nib_hi <= !nib_hi;
                  if (nib_hi) byte_cnt <= byte_cnt + 1'b1;
               end
            end
            RX_DONE: begin
               if (rx_ack) begin
                  state      <= RX_IDLE;
                  rx_done    <= 1'b0;
                  crc_ok     <= 1'b0;
                  addr_match <= 1'b0;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == RX_PRE) begin
         crc      <= '1;
         dest_exp <= MAC_ADDR;
         own_ok   <= 1'b1;
         bcast_ok <= 1'b1;
      end
      if ((state == RX_DATA) && rx_dv && !nib_hi) low_nib <= rx_data;
      if (byte_done) begin
         crc     <= crc32_byte(crc, cur_byte);
         rx_fcs  <= {cur_byte, rx_fcs[31:8]};
         wr_byte <= cur_byte;
         wr_pos  <= byte_cnt;
         // Destination is the first six bytes, sent high byte first
         if (byte_cnt < 11'd6) begin
            own_ok   <= own_ok && (cur_byte == dest_exp[47:40]);
            bcast_ok <= bcast_ok && (cur_byte == 8'hFF);
            dest_exp <= {dest_exp[39:0], 8'h00};
         end
      end
   end

   assign wr = '{we: wr_we, addr: wr_pos[10:2], data: {4{wr_byte}},
                 strb: 4'b0001 << wr_pos[1:0]};

   a_no_write_when_done: assert property (
      @(posedge clk) disable iff (rst_int) (state == RX_DONE) |-> !wr.we
   ) else $error("RX buffer written while holding a frame");

endmodule

/* rtl/eth_mii_tx.sv */
`timescale 1ns/10ps

module eth_mii_tx import eth_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_int,
   input  logic                  send_start,
   input  logic [10:0]           nbytes,
   input  logic                  phy_ready,
   output logic [BUF_ADDR_W-1:0] rd_addr,
   input  logic [31:0]           rd_data,
   output logic                  tx_ready,
   output logic                  tx_en,
   output logic [3:0]            tx_data
);

   tx_state_e   state;
   logic        start_q;
   logic        accept;
   logic [4:0]  cnt;
   logic [10:0] nbytes_q;
   logic [10:0] byte_idx;
   logic [10:0] rd_byte;
   logic        nib_hi;
   logic [31:0] crc;
   logic [7:0]  cur_byte;

   assign tx_ready = (state == TX_IDLE) && !start_q && phy_ready;
   assign accept   = send_start && tx_ready;

   // Address the next byte during the high nibble so its word is ready in time
   assign rd_byte  = byte_idx + {10'd0, nib_hi};
   assign rd_addr  = rd_byte[10:2];
   assign cur_byte = rd_data[{byte_idx[1:0], 3'b000} +: 8];

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         state    <= TX_IDLE;
         start_q  <= 1'b0;
         tx_en    <= 1'b0;
         cnt      <= '0;
         byte_idx <= '0;
         nib_hi   <= 1'b0;
      end else begin
         start_q <= accept;
         case (state)
            TX_IDLE: begin
               if (accept) begin
                  byte_idx <= '0;
                  nib_hi   <= 1'b0;
               end
               if (start_q) begin
                  state <= TX_PRE;
                  tx_en <= 1'b1;
                  cnt   <= '0;
               end
            end
            TX_PRE: begin
               if (cnt == 5'(PREAMBLE_NIBBLES)) begin
                  cnt   <= '0;
                  state <= (nbytes_q == 11'd0) ? TX_FCS : TX_DATA;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            TX_DATA: begin
               nib_hi <= !nib_hi;
               if (nib_hi) begin
                  byte_idx <= byte_idx + 1'b1;
                  if (byte_idx == nbytes_q - 11'd1) state <= TX_FCS;
               end
            end
            TX_FCS: begin
               if (cnt == 5'd7) begin
                  state <= TX_GAP;
                  tx_en <= 1'b0;
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            TX_GAP: begin
               if (cnt == 5'(IFG_CYCLES - 1)) state <= TX_IDLE;
               else cnt <= cnt + 1'b1;
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         nbytes_q <= nbytes;
         crc      <= '1;
      end else if ((state == TX_DATA) && nib_hi) begin
         crc <= crc32_byte(crc, cur_byte);
      end
   end

   always_comb begin
      case (state)
         TX_PRE:  tx_data = (cnt == 5'(PREAMBLE_NIBBLES)) ? 4'hD : 4'h5;
         TX_DATA: tx_data = nib_hi ? cur_byte[7:4] : cur_byte[3:0];
         TX_FCS:  tx_data = ~crc[{cnt[2:0], 2'b00} +: 4];
         default: tx_data = 4'h0;
      endcase
   end

   a_quiet_when_idle: assert property (
      @(posedge clk) disable iff (rst_int) (state inside {TX_IDLE, TX_GAP}) |-> !tx_en
   ) else $error("tx_en high outside a frame");

endmodule

/* rtl/eth_reg_decode.sv */
`timescale 1ns/10ps

module eth_reg_decode import eth_pkg::*; #(
   parameter int PHY_RST_CYCLES = 1048575
) (
   input  logic                  clk,
   input  logic                  rst_int,
   input  cpu_req_t              cpu_in,
   output cpu_rsp_t              cpu_out,
   output buf_wr_t               tx_wr,
   output logic [BUF_ADDR_W-1:0] rx_rd_addr,
   input  logic [31:0]           rx_rd_data,
   input  eth_status_t           status,
   input  logic [10:0]           rx_len,
   input  logic [31:0]           rx_fcs,
   output logic                  send_start,
   output logic                  rx_ack,
   output logic [10:0]           tx_nbytes,
   output logic                  soft_rst,
   output logic                  phy_resetn
);

   localparam int CNT_W = $clog2(PHY_RST_CYCLES + 1);

   logic             ack_q;
   logic             wr_fire;
   logic             rst_regs;
   logic [31:0]      scratch;
   logic [31:0]      rdata;
   logic [CNT_W-1:0] phy_cnt;
   eth_status_t      stat_rd;

   assign rst_regs = rst_int | soft_rst;

   // New request, ack not yet given
   assign wr_fire = cpu_in.req & cpu_in.we & ~ack_q;

   always_ff @(posedge clk or posedge rst_int) begin
      if (rst_int) begin
         ack_q    <= 1'b0;
         soft_rst <= 1'b0;
      end else begin
         ack_q    <= cpu_in.req;
         soft_rst <= wr_fire && (cpu_in.addr == SOFTRST);
      end
   end

   always_ff @(posedge clk or posedge rst_regs) begin
      if (rst_regs) begin
         scratch    <= '0;
         tx_nbytes  <= TX_NBYTES_RST;
         send_start <= 1'b0;
         rx_ack     <= 1'b0;
      end else begin
         send_start <= wr_fire && (cpu_in.addr == SEND) && status.tx_ready;
         rx_ack     <= wr_fire && (cpu_in.addr == RCVACK);
         if (wr_fire && (cpu_in.addr == SCRATCH)) begin
            for (int i = 0; i < 4; i++) begin
               if (cpu_in.wstrb[i]) scratch[8*i +: 8] <= cpu_in.wdata[8*i +: 8];
            end
         end
         if (wr_fire && (cpu_in.addr == TX_NBYTES)) tx_nbytes <= cpu_in.wdata[10:0];
      end
   end

   // PHY held in reset until the count runs out
   always_ff @(posedge clk or posedge rst_regs) begin
      if (rst_regs) begin
         phy_cnt    <= '0;
         phy_resetn <= 1'b0;
      end else if (!phy_resetn) begin
         if (phy_cnt == CNT_W'(PHY_RST_CYCLES - 1)) begin
            phy_resetn <= 1'b1;
         end else begin
            phy_cnt <= phy_cnt + 1'b1;
         end
      end
   end

   always_comb begin
      stat_rd           = status;
      stat_rd.phy_ready = phy_resetn;
      stat_rd.rsvd      = '0;
      case (cpu_in.addr)
         STATUS:    rdata = {16'h0000, stat_rd};
         SCRATCH:   rdata = scratch;
         TX_NBYTES: rdata = {21'd0, tx_nbytes};
         RCV_SIZE:  rdata = {21'd0, rx_len};
         RX_CRC:    rdata = rx_fcs;
         default:   rdata = cpu_in.addr[ETH_ADDR_W-1] ? rx_rd_data : 32'h0;
      endcase
   end

   assign cpu_out = '{ack: ack_q, rdata: rdata};

   // Buffer window, TX written and RX read at the same offset
   assign tx_wr = '{we:   wr_fire & cpu_in.addr[ETH_ADDR_W-1],
                    addr: cpu_in.addr[BUF_ADDR_W-1:0],
                    data: cpu_in.wdata,
                    strb: cpu_in.wstrb};

   assign rx_rd_addr = cpu_in.addr[BUF_ADDR_W-1:0];

   a_ack_needs_req: assert property (
      @(posedge clk) disable iff (rst_int) $rose(ack_q) |-> $past(cpu_in.req)
   ) else $error("ack rose without a request");

endmodule

/* rtl/eth_frame_buf.sv */
`timescale 1ns/10ps

module eth_frame_buf import eth_pkg::*; (
   input  logic                  clk,
   input  buf_wr_t               wr,
   input  logic [BUF_ADDR_W-1:0] rd_addr,
   output logic [31:0]           rd_data
);

   localparam int DEPTH = 1 << BUF_ADDR_W;

   logic [31:0] mem [0:DEPTH-1];

   // Byte lanes written independently
   always_ff @(posedge clk) begin
      if (wr.we) begin
         for (int i = 0; i < 4; i++) begin
            if (wr.strb[i]) begin
               mem[wr.addr][8*i +: 8] <= wr.data[8*i +: 8];
            end
         end
      end
   end

   // One cycle read latency
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

endmodule

/* rtl/eth_pkg.sv */
package eth_pkg;

   localparam int ETH_ADDR_W = 12;
   localparam int BUF_ADDR_W = 9;

   // Register map, addresses with bit 11 set hit the frame buffers
   typedef enum logic [ETH_ADDR_W-1:0] {
      STATUS    = 12'd0,
      SEND      = 12'd1,
      RCVACK    = 12'd2,
      SCRATCH   = 12'd3,
      TX_NBYTES = 12'd4,
      SOFTRST   = 12'd5,
      RCV_SIZE  = 12'd6,
      RX_CRC    = 12'd7
   } eth_reg_e;

   localparam logic [10:0] TX_NBYTES_RST = 11'd60;

   typedef struct packed {
      logic                  req;
      logic                  we;
      logic [ETH_ADDR_W-1:0] addr;
      logic [31:0]           wdata;
      logic [3:0]            wstrb;
   } cpu_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] rdata;
   } cpu_rsp_t;

   // tx_ready ends up in bit 0
   typedef struct packed {
      logic [10:0] rsvd;
      logic        phy_ready;
      logic        addr_match;
      logic        crc_ok;
      logic        rx_done;
      logic        tx_ready;
   } eth_status_t;

   typedef struct packed {
      logic                  we;
      logic [BUF_ADDR_W-1:0] addr;
      logic [31:0]           data;
      logic [3:0]            strb;
   } buf_wr_t;

   typedef enum logic [2:0] {TX_IDLE, TX_PRE, TX_DATA, TX_FCS, TX_GAP} tx_state_e;
   typedef enum logic [1:0] {RX_IDLE, RX_PRE, RX_DATA, RX_DONE} rx_state_e;

   localparam int          PREAMBLE_NIBBLES = 15;
   localparam logic [31:0] CRC_RESIDUE      = 32'hDEBB20E3;
   localparam logic [31:0] CRC_POLY         = 32'hEDB88320;
   localparam int          IFG_CYCLES       = 24;

   // Reflected CRC-32, one byte per call
   function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc ^ {24'h000000, data};
      for (int i = 0; i < 8; i++) begin
         c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
      end
      return c;
   endfunction

endpackage
